// File: rtl/isa_pkg.sv
// Instruction set definitions for the fetch group multiplexer
// Opcode enumeration, instruction field positions,
// the no-operation word and the reset PC

`default_nettype none

package isa_pkg;

	// ========================================
	// Word format
	// ========================================

	localparam int INS_W = 32;

	// Opcode sits in the low bits of every instruction word
	localparam int OP_LSB = 0;
	localparam int OP_MSB = 4;

	typedef enum logic [OP_MSB-OP_LSB:0]
	{
		OP_NOP = 5'd0,
		OP_ALU = 5'd4,
		OP_BL  = 5'd13,
		OP_RET = 5'd14
	} opcode_e;

	// ========================================
	// Branch-and-link fields
	// ========================================

	// Link register number written with the return address
	localparam int LK_LSB = 5;
	localparam int LK_MSB = 7;

	// Link 0 is a plain branch, link 7 is reserved and does nothing
	localparam logic [LK_MSB-LK_LSB:0] LK_NONE = 3'd0;
	localparam logic [LK_MSB-LK_LSB:0] LK_RSV = 3'd7;

	// Signed displacement counted in words, relative to the branch PC
	localparam int DISP_LSB = 8;
	localparam int DISP_MSB = 31;
	localparam int DISP_W = DISP_MSB - DISP_LSB + 1;

	// ========================================
	// Fixed values
	// ========================================

	// All fields other than the opcode are zero
	localparam logic [INS_W-1:0] NOP_WORD = {{(INS_W-OP_MSB-1){1'b0}}, OP_NOP};

	localparam logic [31:0] RST_PC = 32'hFFFC_0000;

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
// Geometry of the cache line and of the fetch group
// Line size, slot count, window width and PC width

`default_nettype none

package fetch_pkg;

	localparam int PC_W = 32;

	// Bytes in one instruction slot
	localparam int SLOT_BYTES = 4;

	// The cache line holds eight instruction words
	localparam int LINE_WORDS = 8;
	localparam int LINE_W = LINE_WORDS * SLOT_BYTES * 8;

	// A group is four consecutive slots taken from the line
	localparam int SLOTS = 4;
	localparam int WIN_W = SLOTS * SLOT_BYTES * 8;

	// Word offset within the line comes from PC bits 4 to 2
	localparam int WOFS_LSB = 2;
	localparam int WOFS_W = 3;

endpackage

`default_nettype wire

// File: rtl/line_aligner.sv
// Window aligner for the fetch group
// Selects four words from the cache line at the fetch PC,
// flags a group that repeats the last one and a changed line

`default_nettype none

module line_aligner
(
	input  wire                          clk,
	input  wire                          rst_i,
	input  wire                          advance_i,
	input  wire [fetch_pkg::LINE_W-1:0]  line_i,
	input  wire [fetch_pkg::PC_W-1:0]    pc_i,
	output logic [fetch_pkg::WIN_W-1:0]  window_o,
	output logic                         redundant_o,
	output logic                         new_line_o
);

	import isa_pkg::*;
	import fetch_pkg::*;

	// ========================================
	// Alignment
	// ========================================

	logic [WOFS_W-1:0] wofs;
	logic [LINE_W+WIN_W-1:0] ext_line;
	logic [LINE_W+WIN_W-1:0] shifted;

	assign wofs = pc_i[WOFS_LSB +: WOFS_W];

	// No-operations above the line fill the slots that run past its end
	assign ext_line = {{SLOTS{NOP_WORD}}, line_i};
	assign shifted = ext_line >> (wofs * INS_W);
	assign window_o = shifted[WIN_W-1:0];

	// ========================================
	// Repeated group detection
	// ========================================

	logic [PC_W-1:0] prev_pc;
	logic [WIN_W-1:0] prev_window;

	// Captured PC starts at the reset vector so the first group always passes
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			prev_pc <= RST_PC;
			prev_window <= '0;
		end
		else if (advance_i)
		begin
			prev_pc <= pc_i;
			prev_window <= window_o;
		end
	end

	assign redundant_o = (pc_i == prev_pc) && (window_o == prev_window);

	// ========================================
	// Line change detection
	// ========================================

	logic [LINE_W-1:0] cur_line;
	logic [LINE_W-1:0] last_line;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cur_line <= '0;
			last_line <= '0;
		end
		else if (advance_i)
		begin
			last_line <= cur_line;
			cur_line <= line_i;
		end
	end

	assign new_line_o = (cur_line != last_line);

endmodule

`default_nettype wire

// File: rtl/slot_register.sv
// Slot register of the fetch group
// Assigns each slot its PC, replaces repeated or missed slots
// with no-operations and registers the group on advance

`default_nettype none

module slot_register
(
	input  wire                                               clk,
	input  wire                                               rst_i,
	input  wire                                               advance_i,
	input  wire [fetch_pkg::WIN_W-1:0]                        window_i,
	input  wire                                               redundant_i,
	input  wire [fetch_pkg::PC_W-1:0]                         pc_i,
	input  wire                                               nmi_i,
	input  wire                                               irq_i,
	input  wire                                               stomp_i,
	input  wire                                               miss_i,
	input  wire [fetch_pkg::PC_W-1:0]                         miss_pc_i,
	output logic [fetch_pkg::SLOTS-1:0][isa_pkg::INS_W-1:0]   slot_ins_o,
	output logic [fetch_pkg::SLOTS-1:0][fetch_pkg::PC_W-1:0]  slot_pc_o,
	output logic                                              slot_v_o,
	output logic                                              nop_o
);

	import isa_pkg::*;
	import fetch_pkg::*;

	// ========================================
	// Slot formation
	// ========================================

	logic [SLOTS-1:0][PC_W-1:0] nxt_pc;
	logic [SLOTS-1:0][INS_W-1:0] nxt_ins;
	logic [SLOTS-1:0] slot_kill;
	logic group_v;

	always_comb
	begin
		for (int k = 0; k < SLOTS; k++)
		begin
			nxt_pc[k] = pc_i + PC_W'(k * SLOT_BYTES);

			// After a branch miss the slots ahead of the target must not execute
			slot_kill[k] = redundant_i || (miss_i && (nxt_pc[k] < miss_pc_i));

			if (slot_kill[k])
				nxt_ins[k] = NOP_WORD;
			else
				nxt_ins[k] = window_i[k*INS_W +: INS_W];
		end
	end

	// An interrupt or a stomp invalidates the whole group
	assign group_v = !(nmi_i || irq_i || stomp_i);

	// ========================================
	// Group registers
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			slot_ins_o <= {SLOTS{NOP_WORD}};
			slot_v_o <= 1'b0;
			nop_o <= 1'b0;
		end
		else if (advance_i)
		begin
			slot_ins_o <= nxt_ins;
			slot_v_o <= group_v;
			nop_o <= stomp_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance_i)
			slot_pc_o <= nxt_pc;
	end

endmodule

`default_nettype wire

// File: rtl/branch_scan.sv
// Flow change scanner for the registered fetch group
// Decodes branch-and-link and return in each slot, picks the
// first flow change and forms its target and return PC

`default_nettype none

module branch_scan
(
	input  wire [fetch_pkg::SLOTS-1:0][isa_pkg::INS_W-1:0]   slot_ins_i,
	input  wire [fetch_pkg::SLOTS-1:0][fetch_pkg::PC_W-1:0]  slot_pc_i,
	input  wire                                              slot_v_i,
	output logic                                             do_branch_o,
	output logic                                             do_call_o,
	output logic                                             do_ret_o,
	output logic [fetch_pkg::PC_W-1:0]                       branch_tgt_o,
	output logic [fetch_pkg::PC_W-1:0]                       ret_pc_o
);

	import isa_pkg::*;
	import fetch_pkg::*;

	// ========================================
	// Per-slot decode
	// ========================================

	opcode_e op [SLOTS];
	logic [SLOTS-1:0][LK_MSB-LK_LSB:0] lk;
	logic [SLOTS-1:0][DISP_W-1:0] disp;
	logic [SLOTS-1:0] is_bl;
	logic [SLOTS-1:0] is_call;
	logic [SLOTS-1:0] is_ret;
	logic [SLOTS-1:0][PC_W-1:0] tgt;

	always_comb
	begin
		for (int k = 0; k < SLOTS; k++)
		begin
			op[k] = opcode_e'(slot_ins_i[k][OP_MSB:OP_LSB]);
			lk[k] = slot_ins_i[k][LK_MSB:LK_LSB];
			disp[k] = slot_ins_i[k][DISP_MSB:DISP_LSB];

			// A reserved link turns the branch-and-link into a no-operation
			is_bl[k] = slot_v_i && (op[k] == OP_BL) && (lk[k] != LK_RSV);
			is_call[k] = is_bl[k] && (lk[k] != LK_NONE);
			is_ret[k] = slot_v_i && (op[k] == OP_RET);

			// Word displacement, sign extended and scaled to bytes
			tgt[k] = slot_pc_i[k]
				+ {{(PC_W-DISP_W-2){disp[k][DISP_W-1]}}, disp[k], 2'b00};
		end
	end

	// ========================================
	// First flow change
	// ========================================

	// Slot 0 is oldest, so the lowest numbered transfer wins
	always_comb
	begin
		logic found;

		found = 1'b0;
		do_branch_o = 1'b0;
		do_call_o = 1'b0;
		do_ret_o = 1'b0;
		branch_tgt_o = RST_PC;
		ret_pc_o = RST_PC;

		for (int k = 0; k < SLOTS; k++)
		begin
			if (!found && (is_bl[k] || is_ret[k]))
			begin
				found = 1'b1;
				do_branch_o = is_bl[k];
				do_call_o = is_call[k];
				do_ret_o = is_ret[k];
				if (is_bl[k])
					branch_tgt_o = tgt[k];
				// Return address is the word after the call
				if (is_call[k])
					ret_pc_o = slot_pc_i[k] + PC_W'(SLOT_BYTES);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/group_mux_top.sv
// Fetch group multiplexer
// Chains the window aligner, the slot register and the
// flow change scanner into one fetch stage

`default_nettype none

module group_mux_top
(
	input  wire                                               clk,
	input  wire                                               rst_i,
	input  wire                                               advance_i,
	input  wire [fetch_pkg::LINE_W-1:0]                       line_i,
	input  wire [fetch_pkg::PC_W-1:0]                         pc_i,
	input  wire                                               nmi_i,
	input  wire                                               irq_i,
	input  wire                                               stomp_i,
	input  wire                                               miss_i,
	input  wire [fetch_pkg::PC_W-1:0]                         miss_pc_i,
	output logic [fetch_pkg::SLOTS-1:0][isa_pkg::INS_W-1:0]   slot_ins_o,
	output logic [fetch_pkg::SLOTS-1:0][fetch_pkg::PC_W-1:0]  slot_pc_o,
	output logic                                              slot_v_o,
	output logic                                              nop_o,
	output logic                                              new_line_o,
	output logic                                              do_branch_o,
	output logic                                              do_call_o,
	output logic                                              do_ret_o,
	output logic [fetch_pkg::PC_W-1:0]                        branch_tgt_o,
	output logic [fetch_pkg::PC_W-1:0]                        ret_pc_o
);

	import fetch_pkg::*;

	logic [WIN_W-1:0] window;
	logic redundant;

	line_aligner u_line_aligner
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.advance_i   (advance_i),
		.line_i      (line_i),
		.pc_i        (pc_i),
		.window_o    (window),
		.redundant_o (redundant),
		.new_line_o  (new_line_o)
	);

	// Group outputs change one cycle after the advance edge
	slot_register u_slot_register
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.advance_i   (advance_i),
		.window_i    (window),
		.redundant_i (redundant),
		.pc_i        (pc_i),
		.nmi_i       (nmi_i),
		.irq_i       (irq_i),
		.stomp_i     (stomp_i),
		.miss_i      (miss_i),
		.miss_pc_i   (miss_pc_i),
		.slot_ins_o  (slot_ins_o),
		.slot_pc_o   (slot_pc_o),
		.slot_v_o    (slot_v_o),
		.nop_o       (nop_o)
	);

	branch_scan u_branch_scan
	(
		.slot_ins_i   (slot_ins_o),
		.slot_pc_i    (slot_pc_o),
		.slot_v_i     (slot_v_o),
		.do_branch_o  (do_branch_o),
		.do_call_o    (do_call_o),
		.do_ret_o     (do_ret_o),
		.branch_tgt_o (branch_tgt_o),
		.ret_pc_o     (ret_pc_o)
	);

endmodule

`default_nettype wire

// File: testbench/group_mux_sva.sv
// Concurrent checks on the flow outputs and the reset state
// Bound into the fetch group multiplexer top level

`default_nettype none

module group_mux_sva
(
	input wire clk,
	input wire rst_i,
	input wire slot_v_i,
	input wire nop_i,
	input wire new_line_i,
	input wire do_branch_i,
	input wire do_call_i,
	input wire do_ret_i
);

	int fail_cnt = 0;

	// A call is a branch that also writes a link register
	call_is_branch: assert property (@(posedge clk) disable iff (rst_i)
		do_call_i |-> do_branch_i)
	else
	begin
		$error("do_call_o is high without do_branch_o");
		fail_cnt++;
	end

	branch_ret_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(do_branch_i && do_ret_i))
	else
	begin
		$error("do_branch_o and do_ret_o are high together");
		fail_cnt++;
	end

	// An invalid group can never redirect the fetch
	flow_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
		(do_branch_i || do_call_i || do_ret_i) |-> slot_v_i)
	else
	begin
		$error("a flow output is high while the group is invalid");
		fail_cnt++;
	end

	reset_quiet: assert property (@(posedge clk)
		rst_i |=> !(slot_v_i || nop_i || new_line_i || do_branch_i || do_call_i || do_ret_i))
	else
	begin
		$error("control outputs are not low after reset");
		fail_cnt++;
	end

endmodule

bind group_mux_top group_mux_sva u_group_mux_sva
(
	.clk         (clk),
	.rst_i       (rst_i),
	.slot_v_i    (slot_v_o),
	.nop_i       (nop_o),
	.new_line_i  (new_line_o),
	.do_branch_i (do_branch_o),
	.do_call_i   (do_call_o),
	.do_ret_i    (do_ret_o)
);

`default_nettype wire

// File: testbench/tb_group_mux.sv
// Testbench for the fetch group multiplexer
// Reads stimulus vectors, models the slot register and checks
// the group and flow outputs one cycle after each advance

`default_nettype none

module tb_group_mux;

	localparam int VEC_W = 396;
	localparam int MAX_VEC = 64;
	localparam int RST_CYCLES = 8;
	localparam int MARGIN = 20;
	localparam logic [31:0] NOP_INS = 32'h0000_0000;
	localparam logic [31:0] RESET_PC = 32'hFFFC_0000;

	logic clk = 1'b0;
	logic rst_i;
	logic advance_i;
	logic [255:0] line_i;
	logic [31:0] pc_i;
	logic nmi_i;
	logic irq_i;
	logic stomp_i;
	logic miss_i;
	logic [31:0] miss_pc_i;
	logic [3:0][31:0] slot_ins_o;
	logic [3:0][31:0] slot_pc_o;
	logic slot_v_o;
	logic nop_o;
	logic new_line_o;
	logic do_branch_o;
	logic do_call_o;
	logic do_ret_o;
	logic [31:0] branch_tgt_o;
	logic [31:0] ret_pc_o;

	group_mux_top u_group_mux_top
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.advance_i    (advance_i),
		.line_i       (line_i),
		.pc_i         (pc_i),
		.nmi_i        (nmi_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.miss_i       (miss_i),
		.miss_pc_i    (miss_pc_i),
		.slot_ins_o   (slot_ins_o),
		.slot_pc_o    (slot_pc_o),
		.slot_v_o     (slot_v_o),
		.nop_o        (nop_o),
		.new_line_o   (new_line_o),
		.do_branch_o  (do_branch_o),
		.do_call_o    (do_call_o),
		.do_ret_o     (do_ret_o),
		.branch_tgt_o (branch_tgt_o),
		.ret_pc_o     (ret_pc_o)
	);

	logic [VEC_W-1:0] vec_mem [MAX_VEC];
	int n_vec;
	int errors;
	int checks;
	int sva_fails;
	int cycle_cnt = 0;
	int cycle_limit = MAX_VEC + RST_CYCLES + MARGIN;

	// Reference model of the registered group
	logic [31:0] m_prev_pc;
	logic [3:0][31:0] m_prev_win;
	logic [255:0] m_cur_line;
	logic [255:0] m_last_line;
	logic [3:0][31:0] m_ins;
	logic [3:0][31:0] m_pc;
	logic m_v;
	logic m_nop;
	logic m_new_line;

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Words that run past the end of the line read as no-operations
	function automatic logic [31:0] window_word(input logic [255:0] line,
		input logic [31:0] pc, input int k);
		int idx;
		idx = int'(pc[4:2]) + k;
		if (idx < 8)
			return line[idx*32 +: 32];
		else
			return NOP_INS;
	endfunction

	task automatic apply_vector(input logic [VEC_W-1:0] v);
		advance_i <= v[392];
		line_i <= v[391:136];
		pc_i <= v[135:104];
		nmi_i <= v[103];
		irq_i <= v[102];
		stomp_i <= v[101];
		miss_i <= v[100];
		miss_pc_i <= v[99:68];
	endtask

	task automatic model_advance(input logic [VEC_W-1:0] v);
		logic [255:0] line;
		logic [31:0] pc;
		logic [31:0] mpc;
		logic [3:0][31:0] win;
		logic red;
		line = v[391:136];
		pc = v[135:104];
		mpc = v[99:68];
		if (v[392])
		begin
			for (int k = 0; k < 4; k++)
				win[k] = window_word(line, pc, k);
			red = (pc == m_prev_pc) && (win == m_prev_win);
			for (int k = 0; k < 4; k++)
			begin
				m_pc[k] = pc + 32'(4 * k);
				if (red || (v[100] && (m_pc[k] < mpc)))
					m_ins[k] = NOP_INS;
				else
					m_ins[k] = win[k];
			end
			m_v = !(v[103] || v[102] || v[101]);
			m_nop = v[101];
			m_prev_pc = pc;
			m_prev_win = win;
			m_last_line = m_cur_line;
			m_cur_line = line;
			m_new_line = (m_cur_line != m_last_line);
		end
	endtask

	task automatic check_group(input int idx, input logic [VEC_W-1:0] v);
		for (int k = 0; k < 4; k++)
		begin
			check_value($sformatf("slot_ins_o[%0d] at vector %0d", k, idx),
				slot_ins_o[k], m_ins[k]);
			check_value($sformatf("slot_pc_o[%0d] at vector %0d", k, idx),
				slot_pc_o[k], m_pc[k]);
		end
		check_value($sformatf("slot_v_o at vector %0d", idx), slot_v_o, m_v);
		check_value($sformatf("nop_o at vector %0d", idx), nop_o, m_nop);
		check_value($sformatf("new_line_o at vector %0d", idx), new_line_o, m_new_line);
		check_value($sformatf("do_branch_o at vector %0d", idx), do_branch_o, v[66]);
		check_value($sformatf("do_call_o at vector %0d", idx), do_call_o, v[65]);
		check_value($sformatf("do_ret_o at vector %0d", idx), do_ret_o, v[64]);
		check_value($sformatf("branch_tgt_o at vector %0d", idx), branch_tgt_o, v[63:32]);
		check_value($sformatf("ret_pc_o at vector %0d", idx), ret_pc_o, v[31:0]);
	endtask

	task automatic check_reset_state();
		for (int k = 0; k < 4; k++)
			check_value($sformatf("slot_ins_o[%0d] after reset", k), slot_ins_o[k], NOP_INS);
		check_value("slot_v_o after reset", slot_v_o, 1'b0);
		check_value("nop_o after reset", nop_o, 1'b0);
		check_value("new_line_o after reset", new_line_o, 1'b0);
		check_value("do_branch_o after reset", do_branch_o, 1'b0);
		check_value("do_call_o after reset", do_call_o, 1'b0);
		check_value("do_ret_o after reset", do_ret_o, 1'b0);
		check_value("branch_tgt_o after reset", branch_tgt_o, RESET_PC);
		check_value("ret_pc_o after reset", ret_pc_o, RESET_PC);
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial
	begin
		rst_i = 1'b1;
		advance_i = 1'b0;
		line_i = '0;
		pc_i = '0;
		nmi_i = 1'b0;
		irq_i = 1'b0;
		stomp_i = 1'b0;
		miss_i = 1'b0;
		miss_pc_i = '0;
		errors = 0;
		checks = 0;
		n_vec = 0;
		m_prev_pc = RESET_PC;
		m_prev_win = '0;
		m_cur_line = '0;
		m_last_line = '0;
		m_ins = '0;
		m_pc = '0;
		m_v = 1'b0;
		m_nop = 1'b0;
		m_new_line = 1'b0;

		// Entries the file leaves unloaded keep F in the advance field, which no vector uses
		for (int i = 0; i < MAX_VEC; i++)
			vec_mem[i] = {4'hF, (VEC_W-4)'(i)};
		$readmemh("testbench/group_mux_stim.txt", vec_mem);
		while ((n_vec < MAX_VEC) && (vec_mem[n_vec][VEC_W-1 -: 4] != 4'hF))
			n_vec++;
		cycle_limit = n_vec + RST_CYCLES + MARGIN;
		if (n_vec == 0)
		begin
			errors++;
			$display("No stimulus vectors could be read from the stimulus file");
		end

		repeat (RST_CYCLES) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		check_reset_state();

		// Each vector is captured on the edge that drives the next one
		for (int i = 0; i <= n_vec; i++)
		begin
			@(posedge clk);
			if (i < n_vec)
				apply_vector(vec_mem[i]);
			else
				advance_i <= 1'b0;
			@(negedge clk);
			if (i > 0)
			begin
				model_advance(vec_mem[i-1]);
				check_group(i - 1, vec_mem[i-1]);
			end
		end

		sva_fails = u_group_mux_top.u_group_mux_sva.fail_cnt;
		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, sva_fails);
		if ((errors == 0) && (sva_fails == 0))
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/group_mux_stim.txt
// adv _ line words 7..0 _ pc _ nmi,irq,stomp,miss _ miss_pc _ branch,call,ret _ target _ return pc
// Flow nibble: 4 = branch, 2 = call, 1 = return; no flow gives FFFC0000 for target and return pc
1_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_00001000_0_00000000_0_FFFC0000_FFFC0000
1_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_0000100C_0_00000000_0_FFFC0000_FFFC0000
1_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_00001018_0_00000000_0_FFFC0000_FFFC0000
1_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_00001018_0_00000000_0_FFFC0000_FFFC0000
0_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_00001000_0_00000000_0_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002000_0_00000000_6_00001FF8_00002008
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002008_0_00000000_1_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002018_0_00000000_1_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_0000200C_0_00000000_4_00002050_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002000_8_00000000_0_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002004_4_00000000_0_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002000_2_00000000_0_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002004_0_00000000_6_00001FF8_00002008
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002000_1_00002008_1_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_0000200C_1_00002014_1_FFFC0000_FFFC0000
1_A7000004A6000004A5000004A4000004A3000004A2000004A1000004A0000004_00001000_0_00000000_0_FFFC0000_FFFC0000
0_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002004_0_00000000_0_FFFC0000_FFFC0000
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002004_0_00000000_6_00001FF8_00002008
1_000005ED0000000EB50000040000100DB30000040000000EFFFFFD2DB0000004_00002004_0_00000000_0_FFFC0000_FFFC0000

// File: vlog.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/line_aligner.sv
rtl/slot_register.sv
rtl/branch_scan.sv
rtl/group_mux_top.sv
testbench/group_mux_sva.sv
testbench/tb_group_mux.sv

// File: Bender.yml
package:
  name: group_mux

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/line_aligner.sv
      - rtl/slot_register.sv
      - rtl/branch_scan.sv
      - rtl/group_mux_top.sv
  - target: test
    files:
      - testbench/group_mux_sva.sv
      - testbench/tb_group_mux.sv
